// ==== all.f ====
+incdir+.
cpuPkg.sv
regFile.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
cpuTop.sv
cpuTb.sv

// ==== cpuTb.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuTb import cpuPkg::*; ();

	localparam int memWords = 1 << `ADDR_W;
	localparam int numTests = 5;

	logic               clk;
	logic               rstN;
	logic [`ADDR_W-1:0] imemAddr;
	logic [`DATA_W-1:0] imemData;
	logic [`ADDR_W-1:0] dmemAddr;
	logic               dmemWe;
	logic [`DATA_W-1:0] dmemWdata;
	logic [`DATA_W-1:0] dmemRdata;
	logic               halted;

	logic [`DATA_W-1:0] imem [memWords];
	logic [`DATA_W-1:0] dmem [memWords];
	logic [`ADDR_W-1:0] obsAddr [$];
	logic [`DATA_W-1:0] obsData [$];
	logic [`ADDR_W-1:0] expAddr [$];
	logic [`DATA_W-1:0] expData [$];

	logic [15:0]        lfsrState;
	int                 progLen;
	int                 jalAddr;
	int                 errors;
	int                 testsRun;
	int                 testsPassed;
	logic               aborted;
	string              testNames [numTests] = '{"arithmetic", "loads", "control flow",
		"subroutine", "reset and halt"};

	cpuTop dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	assign imemData  = imem[imemAddr];
	assign dmemRdata = dmem[dmemAddr];

	// Data memory write port and store log
	always @(posedge clk) begin
		if (dmemWe) begin
			dmem[dmemAddr] <= dmemWdata;
			obsAddr.push_back(dmemAddr);
			obsData.push_back(dmemWdata);
			if (halted) begin
				$display("store seen at %0t while the CPU was halted", $time);
				errors++;
			end
		end
	end

	// Galois LFSR stepped once per bit
	function automatic logic nextBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = (lfsrState >> 1) ^ (outBit ? 16'hB400 : 16'h0000);
		return outBit;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int k = 0; k < n; k++) begin
			val = {val[30:0], nextBit()};
		end
		return val;
	endfunction

	function automatic logic [`REG_IDX_W-1:0] pickReg();
		return `REG_IDX_W'(1 + randBits(3) % 7);
	endfunction

	function automatic logic [`DATA_W-1:0] fillWord(input logic [`ADDR_W-1:0] a);
		return {a, ~a, 12'h5a3};
	endfunction

	// Unused instruction words decode as SYSCALL
	function automatic logic [`DATA_W-1:0] idleWord(input logic [`ADDR_W-1:0] a);
		return {6'b0, a, 10'b0, syscall};
	endfunction

	function automatic logic [`DATA_W-1:0] rTypeWord(input functE f,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
		return {rType, rs, rt, rd, 5'b0, f};
	endfunction

	function automatic logic [`DATA_W-1:0] iTypeWord(input opcodeE op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [`DATA_W-1:0] jTypeWord(input opcodeE op,
		input logic [`ADDR_W-1:0] target);
		return {op, 16'b0, target};
	endfunction

	task automatic emitWord(input logic [`DATA_W-1:0] w);
		imem[progLen] = w;
		progLen++;
	endtask

	task automatic seedRegisters();
		for (int r = 1; r < 8; r++) begin
			emitWord(iTypeWord(li, 5'd0, 5'(r), 16'(randBits(16))));
		end
	endtask

	task automatic emitStores(input int count);
		for (int k = 0; k < count; k++) begin
			emitWord(iTypeWord(sw, 5'd0, pickReg(), 16'(randBits(6))));
		end
	endtask

	task automatic emitArith(input int kind);
		logic [4:0] rd;
		rd = pickReg();
		case (kind)
			0: emitWord(rTypeWord(add, pickReg(), pickReg(), rd));
			1: emitWord(rTypeWord(sub, pickReg(), pickReg(), rd));
			2: emitWord(rTypeWord(slt, pickReg(), pickReg(), rd));
			3: emitWord(iTypeWord(xori, pickReg(), rd, 16'(randBits(16))));
			default: emitWord(iTypeWord(li, 5'd0, rd, 16'(randBits(16))));
		endcase
		emitWord(iTypeWord(sw, 5'd0, rd, 16'(randBits(6))));
	endtask

	task automatic buildProgram(input int id);
		logic [4:0] ra;
		logic [4:0] rb;
		int         kind;
		int         skip;
		seedRegisters();
		case (id)
			0: begin
				for (int n = 0; n < 14; n++) begin
					emitArith(int'(randBits(3) % 5));
				end
			end
			1: begin
				emitStores(6);
				for (int n = 0; n < 10; n++) begin
					kind = int'(randBits(2) % 3);
					ra = pickReg();
					rb = pickReg();
					if (kind == 2) begin
						emitWord(iTypeWord(sw, 5'd0, ra, 16'(randBits(4))));
					end else begin
						emitWord(iTypeWord(lw, 5'd0, ra, 16'(randBits(4))));
						if (kind == 0) begin
							emitWord(rTypeWord(add, ra, rb, rb));
						end
						emitWord(iTypeWord(sw, 5'd0, (kind == 0) ? rb : ra, 16'(randBits(4))));
					end
				end
			end
			2: begin
				for (int n = 0; n < 10; n++) begin
					kind = int'(randBits(2));
					skip = 1 + int'(randBits(2) % 3);
					ra = pickReg();
					rb = nextBit() ? ra : pickReg();
					if (kind == 1) begin
						emitWord(iTypeWord(bne, ra, rb, 16'(skip)));
						emitStores(skip);
					end else if (kind == 2) begin
						emitWord(jTypeWord(j, `ADDR_W'(progLen + 1 + skip)));
						emitStores(skip);
					end else begin
						emitArith(kind == 0 ? 0 : 3);
					end
				end
			end
			3: begin
				// Main path first and the subroutine at jalAddr + 4
				jalAddr = progLen;
				emitWord(jTypeWord(jal, `ADDR_W'(jalAddr + 4)));
				emitWord(iTypeWord(sw, 5'd0, 5'd1, 16'd20));
				emitWord(iTypeWord(sw, 5'd0, 5'(`LINK_REG), 16'd21));
				emitWord(rTypeWord(syscall, 5'd0, 5'd0, 5'd0));
				emitWord(iTypeWord(sw, 5'd0, 5'(`LINK_REG), 16'd22));
				emitWord(iTypeWord(xori, 5'd1, 5'd1, 16'(randBits(16))));
				emitWord(rTypeWord(jr, 5'(`LINK_REG), 5'd0, 5'd0));
			end
			default: begin
				emitWord(iTypeWord(sw, 5'd0, 5'd1, 16'd30));
				emitWord(iTypeWord(sw, 5'd0, 5'd2, 16'd31));
				emitWord(rTypeWord(syscall, 5'd0, 5'd0, 5'd0));
				emitWord(iTypeWord(sw, 5'd0, 5'd3, 16'd32));
				emitWord(iTypeWord(sw, 5'd0, 5'd4, 16'd33));
			end
		endcase
		emitWord(rTypeWord(syscall, 5'd0, 5'd0, 5'd0));
	endtask

	// ISA-level model that runs one instruction per step
	task automatic runModel();
		logic [`DATA_W-1:0] mregs [`NUM_REGS];
		logic [`DATA_W-1:0] mmem [memWords];
		logic [`ADDR_W-1:0] pc;
		logic [`ADDR_W-1:0] ea;
		logic [`DATA_W-1:0] w;
		logic [`DATA_W-1:0] imm;
		logic [4:0]         rs;
		logic [4:0]         rt;
		logic [4:0]         rd;
		logic               done;
		int                 steps;
		for (int k = 0; k < `NUM_REGS; k++) begin
			mregs[k] = '0;
		end
		for (int k = 0; k < memWords; k++) begin
			mmem[k] = fillWord(`ADDR_W'(k));
		end
		expAddr.delete();
		expData.delete();
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 2000) begin
			w = imem[pc];
			rs = w[25:21];
			rt = w[20:16];
			rd = w[15:11];
			imm = {{16{w[15]}}, w[15:0]};
			ea = mregs[rs][`ADDR_W-1:0] + imm[`ADDR_W-1:0];
			pc = pc + 1'b1;
			case (opcodeE'(w[31:26]))
				rType: begin
					case (functE'(w[5:0]))
						add: mregs[rd] = mregs[rs] + mregs[rt];
						sub: mregs[rd] = mregs[rs] - mregs[rt];
						slt: mregs[rd] = ($signed(mregs[rs]) < $signed(mregs[rt])) ? 1 : 0;
						jr: pc = mregs[rs][`ADDR_W-1:0];
						syscall: done = 1'b1;
						default: done = 1'b1;
					endcase
				end
				li: mregs[rt] = imm;
				xori: mregs[rt] = mregs[rs] ^ imm;
				lw: mregs[rt] = mmem[ea];
				sw: begin
					mmem[ea] = mregs[rt];
					expAddr.push_back(ea);
					expData.push_back(mregs[rt]);
				end
				bne: begin
					if (mregs[rs] != mregs[rt]) begin
						pc = pc + imm[`ADDR_W-1:0];
					end
				end
				j: pc = w[`ADDR_W-1:0];
				jal: begin
					mregs[`LINK_REG] = `DATA_W'(pc);
					pc = w[`ADDR_W-1:0];
				end
				default: done = 1'b1;
			endcase
			mregs[0] = '0;
			steps++;
		end
	endtask

	task automatic checkAddr(input logic [`ADDR_W-1:0] got, input logic [`ADDR_W-1:0] exp,
		input string name);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkData(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
		input string name);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkBit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compareStores();
		int n;
		if (obsAddr.size() != expAddr.size()) begin
			$display("CPU made %0d stores, model expects %0d", obsAddr.size(), expAddr.size());
			errors++;
		end
		n = (obsAddr.size() < expAddr.size()) ? obsAddr.size() : expAddr.size();
		for (int k = 0; k < n; k++) begin
			checkAddr(obsAddr[k], expAddr[k], "dmemAddr");
			checkData(obsData[k], expData[k], "dmemWdata");
		end
	endtask

	task automatic waitHalted(output logic timedOut);
		timedOut = 1'b1;
		for (int cycles = 0; cycles < 2000; cycles++) begin
			@(negedge clk);
			if (halted) begin
				timedOut = 1'b0;
				break;
			end
		end
	endtask

	task automatic runTest(input int id);
		logic timedOut;
		int   errorsBefore;
		errorsBefore = errors;
		@(negedge clk);
		rstN = 1'b0;
		progLen = 0;
		for (int a = 0; a < memWords; a++) begin
			imem[a] = idleWord(`ADDR_W'(a));
			dmem[a] = fillWord(`ADDR_W'(a));
		end
		buildProgram(id);
		runModel();
		obsAddr.delete();
		obsData.delete();
		repeat (4) @(negedge clk);
		checkBit(dmemWe, 1'b0, "dmemWe");
		checkBit(halted, 1'b0, "halted");
		checkAddr(imemAddr, '0, "imemAddr");
		rstN = 1'b1;
		waitHalted(timedOut);
		testsRun++;
		if (timedOut) begin
			$display("test %0d %s: halted did not rise within 2000 cycles", id, testNames[id]);
			errors++;
			aborted = 1'b1;
		end else begin
			// Quiet window after halt
			repeat (10) @(negedge clk);
			checkBit(halted, 1'b1, "halted");
			compareStores();
			if (id == 3 && obsData.size() > 0) begin
				checkData(obsData[0], `DATA_W'(jalAddr + 1), "link value");
			end
			if (errors == errorsBefore) begin
				testsPassed++;
			end
			$display("test %0d %s: %0d stores, %s", id, testNames[id], obsAddr.size(),
				(errors == errorsBefore) ? "ok" : "mismatch");
		end
	endtask

	initial begin
		rstN = 1'b0;
		lfsrState = 16'd1094;
		progLen = 0;
		jalAddr = 0;
		errors = 0;
		testsRun = 0;
		testsPassed = 0;
		aborted = 1'b0;
		for (int a = 0; a < memWords; a++) begin
			imem[a] = idleWord(`ADDR_W'(a));
			dmem[a] = fillWord(`ADDR_W'(a));
		end
		for (int t = 0; t < numTests && !aborted; t++) begin
			runTest(t);
		end
		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			testsRun, testsPassed, testsRun - testsPassed, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuTop import cpuPkg::*; (
	input  logic               clk,
	input  logic               rstN,
	output logic [`ADDR_W-1:0] imemAddr,
	input  logic [`DATA_W-1:0] imemData,
	output logic [`ADDR_W-1:0] dmemAddr,
	output logic               dmemWe,
	output logic [`DATA_W-1:0] dmemWdata,
	input  logic [`DATA_W-1:0] dmemRdata,
	output logic               halted
);

	// Fetch and decode control
	logic                  stall;
	logic                  haltFetch;
	logic                  exRedirect;
	logic [`ADDR_W-1:0]    exTarget;
	logic                  idRedirect;
	logic [`ADDR_W-1:0]    idTarget;
	logic                  ifIdValid;
	logic [`DATA_W-1:0]    ifIdInstr;
	logic [`ADDR_W-1:0]    ifIdPcNext;
	logic [`REG_IDX_W-1:0] rdAddrA;
	logic [`REG_IDX_W-1:0] rdAddrB;
	logic [`DATA_W-1:0]    rdDataA;
	logic [`DATA_W-1:0]    rdDataB;
	logic                  exIsLoad;
	logic [`REG_IDX_W-1:0] exDestReg;

	// ID/EX
	logic                  idExValid;
	opcodeE                idExOp;
	functE                 idExFunct;
	logic [`REG_IDX_W-1:0] idExRs;
	logic [`REG_IDX_W-1:0] idExRt;
	logic [`DATA_W-1:0]    idExA;
	logic [`DATA_W-1:0]    idExB;
	logic [`DATA_W-1:0]    idExImm;
	logic [`REG_IDX_W-1:0] idExDest;
	wbSelE                 idExWbSel;
	logic [`ADDR_W-1:0]    idExPcNext;
	logic [`ADDR_W-1:0]    idExBranchTarget;

	// EX/MEM and writeback
	logic                  exMemValid;
	opcodeE                exMemOp;
	logic [`DATA_W-1:0]    exMemResult;
	logic [`DATA_W-1:0]    exMemStoreData;
	logic [`REG_IDX_W-1:0] exMemDest;
	wbSelE                 exMemWbSel;
	logic                  exMemHalt;
	logic                  memFwdWe;
	logic [`REG_IDX_W-1:0] memFwdReg;
	logic [`DATA_W-1:0]    memFwdData;
	logic                  wbWe;
	logic [`REG_IDX_W-1:0] wbReg;
	logic [`DATA_W-1:0]    wbData;

	regFile uRegFile (
		.clk(clk), .rstN(rstN),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.rdDataA(rdDataA), .rdDataB(rdDataB),
		.wrEn(wbWe), .wrAddr(wbReg), .wrData(wbData)
	);

	fetchStage uFetch (.*);

	// Taken branch or JR in execute squashes decode
	decodeStage uDecode (.flush(exRedirect), .*);

	executeStage uExecute (.*);

	memWbStage uMemWb (.*);

endmodule

// ==== memWbStage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module memWbStage import cpuPkg::*; (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  exMemValid,
	input  opcodeE                exMemOp,
	input  logic [`DATA_W-1:0]    exMemResult,
	input  logic [`DATA_W-1:0]    exMemStoreData,
	input  logic [`REG_IDX_W-1:0] exMemDest,
	input  wbSelE                 exMemWbSel,
	input  logic                  exMemHalt,
	input  logic [`DATA_W-1:0]    dmemRdata,
	output logic [`ADDR_W-1:0]    dmemAddr,
	output logic                  dmemWe,
	output logic [`DATA_W-1:0]    dmemWdata,
	output logic                  memFwdWe,
	output logic [`REG_IDX_W-1:0] memFwdReg,
	output logic [`DATA_W-1:0]    memFwdData,
	output logic                  wbWe,
	output logic [`REG_IDX_W-1:0] wbReg,
	output logic [`DATA_W-1:0]    wbData,
	output logic                  halted
);

	logic  memWbValid;
	logic  memWbHalt;
	wbSelE memWbWbSel;

	assign dmemAddr  = exMemResult[`ADDR_W-1:0];
	assign dmemWe    = exMemValid && exMemOp == sw;
	assign dmemWdata = exMemStoreData;

	// Loads are not forwarded from here, decode stalls for them
	assign memFwdWe   = exMemValid && (exMemWbSel == wbAlu || exMemWbSel == wbLink);
	assign memFwdReg  = exMemDest;
	assign memFwdData = exMemResult;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memWbValid <= 1'b0;
			memWbHalt  <= 1'b0;
			halted     <= 1'b0;
		end else begin
			memWbValid <= exMemValid;
			memWbHalt  <= exMemValid && exMemHalt;
			halted     <= halted || memWbHalt;
		end
	end

	always_ff @(posedge clk) begin
		memWbWbSel <= exMemWbSel;
		wbReg      <= exMemDest;
		wbData     <= (exMemWbSel == wbMem) ? dmemRdata : exMemResult;
	end

	assign wbWe = memWbValid && memWbWbSel != wbNone;

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module executeStage import cpuPkg::*; (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  idExValid,
	input  opcodeE                idExOp,
	input  functE                 idExFunct,
	input  logic [`REG_IDX_W-1:0] idExRs,
	input  logic [`REG_IDX_W-1:0] idExRt,
	input  logic [`DATA_W-1:0]    idExA,
	input  logic [`DATA_W-1:0]    idExB,
	input  logic [`DATA_W-1:0]    idExImm,
	input  logic [`REG_IDX_W-1:0] idExDest,
	input  wbSelE                 idExWbSel,
	input  logic [`ADDR_W-1:0]    idExPcNext,
	input  logic [`ADDR_W-1:0]    idExBranchTarget,
	input  logic                  memFwdWe,
	input  logic [`REG_IDX_W-1:0] memFwdReg,
	input  logic [`DATA_W-1:0]    memFwdData,
	input  logic                  wbWe,
	input  logic [`REG_IDX_W-1:0] wbReg,
	input  logic [`DATA_W-1:0]    wbData,
	output logic                  exRedirect,
	output logic [`ADDR_W-1:0]    exTarget,
	output logic                  exIsLoad,
	output logic [`REG_IDX_W-1:0] exDestReg,
	output logic                  exMemValid,
	output opcodeE                exMemOp,
	output logic [`DATA_W-1:0]    exMemResult,
	output logic [`DATA_W-1:0]    exMemStoreData,
	output logic [`REG_IDX_W-1:0] exMemDest,
	output wbSelE                 exMemWbSel,
	output logic                  exMemHalt
);

	logic [`DATA_W-1:0] opA;
	logic [`DATA_W-1:0] opB;
	logic [`DATA_W-1:0] result;
	logic               takenBne;
	logic               isJr;
	logic               isSyscall;

	// Newest producer wins, register 0 never forwarded
	function automatic logic [`DATA_W-1:0] fwdOperand(
		input logic [`REG_IDX_W-1:0] src,
		input logic [`DATA_W-1:0]    regVal
	);
		if (memFwdWe && memFwdReg != '0 && memFwdReg == src) begin
			return memFwdData;
		end else if (wbWe && wbReg != '0 && wbReg == src) begin
			return wbData;
		end
		return regVal;
	endfunction

	assign opA = fwdOperand(idExRs, idExA);
	assign opB = fwdOperand(idExRt, idExB);

	always_comb begin
		result = '0;
		case (idExOp)
			rType: begin
				case (idExFunct)
					add:     result = opA + opB;
					sub:     result = opA - opB;
					slt:     result = {{(`DATA_W-1){1'b0}}, $signed(opA) < $signed(opB)};
					default: result = '0;
				endcase
			end
			xori:    result = opA ^ idExImm;
			li:      result = idExImm;
			lw, sw:  result = opA + idExImm;
			jal:     result = {{(`DATA_W-`ADDR_W){1'b0}}, idExPcNext};
			default: result = '0;
		endcase
	end

	assign takenBne  = idExValid && idExOp == bne && opA != opB;
	assign isJr      = idExValid && idExOp == rType && idExFunct == jr;
	assign isSyscall = idExValid && idExOp == rType && idExFunct == syscall;

	assign exRedirect = takenBne || isJr;
	assign exTarget   = takenBne ? idExBranchTarget : opA[`ADDR_W-1:0];

	// Seen by decode for the load-use check
	assign exIsLoad  = idExValid && idExOp == lw;
	assign exDestReg = idExDest;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exMemValid <= 1'b0;
			exMemHalt  <= 1'b0;
		end else begin
			exMemValid <= idExValid;
			exMemHalt  <= isSyscall;
		end
	end

	always_ff @(posedge clk) begin
		exMemOp        <= idExOp;
		exMemResult    <= result;
		exMemStoreData <= opB;
		exMemDest      <= idExDest;
		exMemWbSel     <= idExWbSel;
	end

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decodeStage import cpuPkg::*; (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  ifIdValid,
	input  logic [`DATA_W-1:0]    ifIdInstr,
	input  logic [`ADDR_W-1:0]    ifIdPcNext,
	input  logic                  flush,
	input  logic [`DATA_W-1:0]    rdDataA,
	input  logic [`DATA_W-1:0]    rdDataB,
	input  logic                  exIsLoad,
	input  logic [`REG_IDX_W-1:0] exDestReg,
	output logic [`REG_IDX_W-1:0] rdAddrA,
	output logic [`REG_IDX_W-1:0] rdAddrB,
	output logic                  idRedirect,
	output logic [`ADDR_W-1:0]    idTarget,
	output logic                  stall,
	output logic                  haltFetch,
	output logic                  idExValid,
	output opcodeE                idExOp,
	output functE                 idExFunct,
	output logic [`REG_IDX_W-1:0] idExRs,
	output logic [`REG_IDX_W-1:0] idExRt,
	output logic [`DATA_W-1:0]    idExA,
	output logic [`DATA_W-1:0]    idExB,
	output logic [`DATA_W-1:0]    idExImm,
	output logic [`REG_IDX_W-1:0] idExDest,
	output wbSelE                 idExWbSel,
	output logic [`ADDR_W-1:0]    idExPcNext,
	output logic [`ADDR_W-1:0]    idExBranchTarget
);

	opcodeE                op;
	functE                 funct;
	logic [`REG_IDX_W-1:0] rs;
	logic [`REG_IDX_W-1:0] rt;
	logic [`REG_IDX_W-1:0] rd;
	logic [`DATA_W-1:0]    imm;
	logic [`REG_IDX_W-1:0] dest;
	wbSelE                 wbSel;
	logic                  usesRs;
	logic                  usesRt;
	logic                  isSyscall;
	logic                  haltSeen;

	assign op    = opcodeE'(ifIdInstr[31:26]);
	assign funct = functE'(ifIdInstr[5:0]);
	assign rs    = ifIdInstr[25:21];
	assign rt    = ifIdInstr[20:16];
	assign rd    = ifIdInstr[15:11];
	assign imm   = {{(`DATA_W-16){ifIdInstr[15]}}, ifIdInstr[15:0]};

	assign rdAddrA = rs;
	assign rdAddrB = rt;

	// Destination, writeback kind and source usage per opcode
	always_comb begin
		dest   = '0;
		wbSel  = wbNone;
		usesRs = 1'b0;
		usesRt = 1'b0;
		case (op)
			rType: begin
				if (funct == add || funct == sub || funct == slt) begin
					dest   = rd;
					wbSel  = wbAlu;
					usesRs = 1'b1;
					usesRt = 1'b1;
				end else if (funct == jr) begin
					usesRs = 1'b1;
				end
			end
			li: begin
				dest  = rt;
				wbSel = wbAlu;
			end
			xori: begin
				dest   = rt;
				wbSel  = wbAlu;
				usesRs = 1'b1;
			end
			lw: begin
				dest   = rt;
				wbSel  = wbMem;
				usesRs = 1'b1;
			end
			sw, bne: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			jal: begin
				dest  = `REG_IDX_W'(`LINK_REG);
				wbSel = wbLink;
			end
			default: wbSel = wbNone;
		endcase
	end

	// Load in execute feeding this instruction
	assign stall = ifIdValid && exIsLoad && exDestReg != '0 &&
		((usesRs && rs == exDestReg) || (usesRt && rt == exDestReg));

	assign idRedirect = ifIdValid && (op == j || op == jal);
	assign idTarget   = ifIdInstr[`ADDR_W-1:0];

	assign isSyscall = ifIdValid && !flush && op == rType && funct == syscall;
	assign haltFetch = isSyscall || haltSeen;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			haltSeen  <= 1'b0;
			idExValid <= 1'b0;
		end else begin
			haltSeen  <= haltSeen || isSyscall;
			idExValid <= ifIdValid && !stall && !flush;
		end
	end

	always_ff @(posedge clk) begin
		idExOp           <= op;
		idExFunct        <= funct;
		idExRs           <= rs;
		idExRt           <= rt;
		idExA            <= rdDataA;
		idExB            <= rdDataB;
		idExImm          <= imm;
		idExDest         <= dest;
		idExWbSel        <= wbSel;
		idExPcNext       <= ifIdPcNext;
		idExBranchTarget <= ifIdPcNext + imm[`ADDR_W-1:0];
	end

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetchStage (
	input  logic               clk,
	input  logic               rstN,
	output logic [`ADDR_W-1:0] imemAddr,
	input  logic [`DATA_W-1:0] imemData,
	input  logic               stall,
	input  logic               haltFetch,
	input  logic               exRedirect,
	input  logic [`ADDR_W-1:0] exTarget,
	input  logic               idRedirect,
	input  logic [`ADDR_W-1:0] idTarget,
	output logic               ifIdValid,
	output logic [`DATA_W-1:0] ifIdInstr,
	output logic [`ADDR_W-1:0] ifIdPcNext
);

	logic [`ADDR_W-1:0] pc;
	logic [`ADDR_W-1:0] pcPlusOne;

	assign imemAddr  = pc;
	assign pcPlusOne = pc + 1'b1;

	// Execute redirect wins over decode jump
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc        <= '0;
			ifIdValid <= 1'b0;
		end else if (exRedirect) begin
			pc        <= exTarget;
			ifIdValid <= 1'b0;
		end else if (idRedirect) begin
			pc        <= idTarget;
			ifIdValid <= 1'b0;
		end else if (!stall) begin
			if (haltFetch) begin
				ifIdValid <= 1'b0;
			end else begin
				pc        <= pcPlusOne;
				ifIdValid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifIdInstr  <= imemData;
			ifIdPcNext <= pcPlusOne;
		end
	end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module regFile (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic [`REG_IDX_W-1:0] rdAddrA,
	input  logic [`REG_IDX_W-1:0] rdAddrB,
	output logic [`DATA_W-1:0]    rdDataA,
	output logic [`DATA_W-1:0]    rdDataB,
	input  logic                  wrEn,
	input  logic [`REG_IDX_W-1:0] wrAddr,
	input  logic [`DATA_W-1:0]    wrData
);

	logic [`DATA_W-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Same-cycle write is visible to decode
	assign rdDataA = (rdAddrA == '0) ? '0 :
		(wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 :
		(wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

	// Primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		rType = 6'b000000,
		j     = 6'b000010,
		jal   = 6'b000011,
		bne   = 6'b000101,
		li    = 6'b001001,
		xori  = 6'b001110,
		lw    = 6'b100011,
		sw    = 6'b101011
	} opcodeE;

	// R-type function codes, instr[5:0]
	typedef enum logic [5:0] {
		jr      = 6'b001000,
		syscall = 6'b001100,
		add     = 6'b100000,
		sub     = 6'b100010,
		slt     = 6'b101010
	} functE;

	// Writeback source
	typedef enum logic [1:0] {
		wbNone = 2'd0,
		wbAlu  = 2'd1,
		wbMem  = 2'd2,
		wbLink = 2'd3
	} wbSelE;

endpackage

// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Register and memory word width
`define DATA_W 32

// Word address width for instruction and data memory
`define ADDR_W 10

// Register file geometry
`define REG_IDX_W 5
`define NUM_REGS 32

// JAL return address register
`define LINK_REG 31

`endif
